// ==== hw/chip_test_defines.svh ====
`ifndef CHIP_TEST_DEFINES_SVH
`define CHIP_TEST_DEFINES_SVH

// bus and memory widths
`define WORD_W          128
`define ADDR_W          7
`define CODE_LSB        18      // interface code sits on data_in[21:18]
`define LEN_W           6
`define CNT_W           4

// words per transfer
`define LEN_CFG         4
`define LEN_WEIADDR     3
`define LEN_FLGWEI      8
`define LEN_WEI         8
`define LEN_FLGACT      8
`define LEN_ACT         8
`define LEN_OFM         4
`define LEN_FLGOFM      4
`define LEN_DEFAULT     2       // unknown codes

// blocks per region, the pointer walks these circularly
`define BLK_CFG         1
`define BLK_WEIADDR     2
`define BLK_FLGWEI      1
`define BLK_WEI         2
`define BLK_FLGACT      4
`define BLK_ACT         4
`define BLK_OFM         1
`define BLK_FLGOFM      1

// region start addresses, each packed right after the previous one
`define BASE_CFG        0
`define BASE_WEIADDR    (`BASE_CFG     + `LEN_CFG     * `BLK_CFG)
`define BASE_FLGWEI     (`BASE_WEIADDR + `LEN_WEIADDR * `BLK_WEIADDR)
`define BASE_WEI        (`BASE_FLGWEI  + `LEN_FLGWEI  * `BLK_FLGWEI)
`define BASE_FLGACT     (`BASE_WEI     + `LEN_WEI     * `BLK_WEI)
`define BASE_ACT        (`BASE_FLGACT  + `LEN_FLGACT  * `BLK_FLGACT)
`define BASE_OFM        (`BASE_ACT     + `LEN_ACT     * `BLK_ACT)
`define BASE_FLGOFM     (`BASE_OFM     + `LEN_OFM     * `BLK_OFM)

`define RELEASE_COUNT   3       // weight-address transfers before clock release

`endif

// ==== hw/chip_test_pkg.sv ====
`include "chip_test_defines.svh"

package chip_test_pkg;

    // interface code driven by the ASIC on the request word
    typedef enum logic [3:0] {
        CFG     = 4'd0,
        FLGOFM  = 4'd1,
        OFM     = 4'd2,
        WEIADDR = 4'd3,
        WEI     = 4'd4,
        FLGWEI  = 4'd5,
        ACT     = 4'd6,
        FLGACT  = 4'd7,
        EMPTY   = 4'd15
    } ifcode_e;

    typedef enum logic [1:0] {IDLE, CONFIG, WAIT, RD_DATA} xfer_state_e;

    typedef enum logic [2:0] {
        IDLE_RST,
        PULLDOWN_SW,
        PULLDOWN_RST_N,
        PULLUP_RST_N,
        PULLUP_SW
    } seq_state_e;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    // words moved per transfer for each code
    function automatic logic [`LEN_W-1:0] code_len(ifcode_e c);
        case (c)
            CFG:     return `LEN_W'(`LEN_CFG);
            WEIADDR: return `LEN_W'(`LEN_WEIADDR);
            FLGWEI:  return `LEN_W'(`LEN_FLGWEI);
            WEI:     return `LEN_W'(`LEN_WEI);
            FLGACT:  return `LEN_W'(`LEN_FLGACT);
            ACT:     return `LEN_W'(`LEN_ACT);
            OFM:     return `LEN_W'(`LEN_OFM);
            FLGOFM:  return `LEN_W'(`LEN_FLGOFM);
            default: return `LEN_W'(`LEN_DEFAULT);
        endcase
    endfunction

endpackage

// ==== hw/chip_reset_sequencer.sv ====
`timescale 1ns/1ps
`include "chip_test_defines.svh"

module chip_reset_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    xfer_done,
    input  chip_test_pkg::ifcode_e  code,
    input  logic                    error,
    output logic                    chip_clk_en,
    output logic                    chip_reset_n
);
    import chip_test_pkg::*;

    seq_state_e         seq_state;
    seq_state_e         seq_next;
    logic [`CNT_W-1:0]  weiaddr_cnt;    // finished WEIADDR transfers
    logic               release_hit;

    assign release_hit = (weiaddr_cnt >= `CNT_W'(`RELEASE_COUNT)) || error;

    // ==========================================================
    // sequence FSM, one step per cycle until PULLUP_SW
    // ==========================================================
    always_comb begin
        seq_next = seq_state;
        case (seq_state)
            IDLE_RST:       if (start) seq_next = PULLDOWN_SW;
            PULLDOWN_SW:    seq_next = PULLDOWN_RST_N;
            PULLDOWN_RST_N: seq_next = PULLUP_RST_N;
            PULLUP_RST_N:   seq_next = PULLUP_SW;
            PULLUP_SW:      if (release_hit) seq_next = IDLE_RST;
            default:        seq_next = IDLE_RST;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq_state <= IDLE_RST;
        end else begin
            seq_state <= seq_next;
        end
    end

    // only counts while the chip clock is switched back on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiaddr_cnt <= '0;
        end else if (seq_state != PULLUP_SW) begin
            weiaddr_cnt <= '0;
        end else if (xfer_done && code == WEIADDR) begin
            weiaddr_cnt <= weiaddr_cnt + 1'b1;
        end
    end

    // outputs follow the next state so they line up with the state itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chip_clk_en  <= 1'b0;
            chip_reset_n <= 1'b1;
        end else begin
            chip_reset_n <= (seq_next != PULLDOWN_RST_N);
            if (seq_next == PULLDOWN_SW) begin
                chip_clk_en <= 1'b0;
            end else if (seq_next == PULLUP_SW) begin
                chip_clk_en <= 1'b1;            // held on after release
            end
        end
    end

    a_reset_pulse_short: assert property (
        @(posedge clk) disable iff (!rst_n) !chip_reset_n |=> chip_reset_n
    );

endmodule

// ==== hw/transfer_sequencer.sv ====
`timescale 1ns/1ps
`include "chip_test_defines.svh"

module transfer_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        config_req,
    input  chip_test_pkg::word_t        data_in,
    output chip_test_pkg::xfer_state_e  state,
    output chip_test_pkg::xfer_state_e  next_state,
    output chip_test_pkg::ifcode_e      code,
    output logic                        xfer_done,
    output logic                        error
);
    import chip_test_pkg::*;

    logic               req_q;      // request level
    logic               req_qq;     // one more stage for the edge
    logic [`LEN_W-1:0]  len;
    logic [`LEN_W-1:0]  rd_cnt;
    logic               last_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            req_qq <= 1'b0;
        end else begin
            req_q  <= config_req;
            req_qq <= req_q;
        end
    end

    assign len     = code_len(code);
    assign last_rd = (state == RD_DATA) && (rd_cnt == len - 1'b1);

    // ==========================================================
    // phase FSM
    // ==========================================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (req_q) next_state = CONFIG;
            CONFIG:  next_state = WAIT;
            WAIT:    next_state = RD_DATA;
            RD_DATA: if (last_rd) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // code is taken from the bus at the same edge that enters CONFIG
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code <= EMPTY;
        end else if (state == IDLE && next_state == CONFIG) begin
            code <= ifcode_e'(data_in[`CODE_LSB +: 4]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
        end else if (state == RD_DATA && !last_rd) begin
            rd_cnt <= rd_cnt + 1'b1;
        end else begin
            rd_cnt <= '0;
        end
    end

    assign xfer_done = last_rd;

    // new request while busy, flagged only, the transfer runs on
    assign error = req_q && !req_qq && (state != IDLE);

    a_rd_within_len: assert property (
        @(posedge clk) disable iff (!rst_n) (state == RD_DATA) |-> (rd_cnt < len)
    );

endmodule

// ==== hw/region_addresser.sv ====
`timescale 1ns/1ps
`include "chip_test_defines.svh"

module region_addresser (
    input  logic                        clk,
    input  logic                        rst_n,
    input  chip_test_pkg::xfer_state_e  state,
    input  chip_test_pkg::xfer_state_e  next_state,
    input  chip_test_pkg::ifcode_e      code,
    input  logic                        xfer_done,
    input  logic                        switch_rdwr,
    output chip_test_pkg::addr_t        mem_addr,
    output logic                        mem_en
);
    import chip_test_pkg::*;

    addr_t          offset [8];     // one circular pointer per known code
    addr_t          rd_addr;
    addr_t          off_step;
    addr_t          off_next;
    logic [2:0]     idx;
    logic           known;

    function automatic addr_t region_base(ifcode_e c);
        case (c)
            CFG:     return `ADDR_W'(`BASE_CFG);
            WEIADDR: return `ADDR_W'(`BASE_WEIADDR);
            FLGWEI:  return `ADDR_W'(`BASE_FLGWEI);
            WEI:     return `ADDR_W'(`BASE_WEI);
            FLGACT:  return `ADDR_W'(`BASE_FLGACT);
            ACT:     return `ADDR_W'(`BASE_ACT);
            OFM:     return `ADDR_W'(`BASE_OFM);
            FLGOFM:  return `ADDR_W'(`BASE_FLGOFM);
            default: return '0;
        endcase
    endfunction

    // region size, length times block count
    function automatic addr_t region_span(ifcode_e c);
        case (c)
            CFG:     return `ADDR_W'(`LEN_CFG * `BLK_CFG);
            WEIADDR: return `ADDR_W'(`LEN_WEIADDR * `BLK_WEIADDR);
            FLGWEI:  return `ADDR_W'(`LEN_FLGWEI * `BLK_FLGWEI);
            WEI:     return `ADDR_W'(`LEN_WEI * `BLK_WEI);
            FLGACT:  return `ADDR_W'(`LEN_FLGACT * `BLK_FLGACT);
            ACT:     return `ADDR_W'(`LEN_ACT * `BLK_ACT);
            OFM:     return `ADDR_W'(`LEN_OFM * `BLK_OFM);
            FLGOFM:  return `ADDR_W'(`LEN_FLGOFM * `BLK_FLGOFM);
            default: return '0;
        endcase
    endfunction

    assign idx      = code[2:0];
    assign known    = code inside {CFG, FLGOFM, OFM, WEIADDR, WEI, FLGWEI, ACT, FLGACT};
    assign off_step = offset[idx] + `ADDR_W'(code_len(code));
    assign off_next = (off_step >= region_span(code)) ? '0 : off_step;    // wrap

    // pointer moves only after a completed read transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                offset[i] <= '0;
            end
        end else if (xfer_done && switch_rdwr && known) begin
            offset[idx] <= off_next;
        end
    end

    // start address set in CONFIG, then one step per read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (state == CONFIG) begin
            rd_addr <= known ? region_base(code) + offset[idx] : '0;
        end else if (mem_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    assign mem_en   = (next_state == RD_DATA);     // one cycle ahead of the bus
    assign mem_addr = rd_addr;

endmodule

// ==== hw/pattern_memory.sv ====
`timescale 1ns/1ps
`include "chip_test_defines.svh"

module pattern_memory (
    input  logic                    clk,
    input  logic                    load_en,
    input  chip_test_pkg::addr_t    load_addr,
    input  chip_test_pkg::word_t    load_data,
    input  logic                    rd_en,
    input  chip_test_pkg::addr_t    rd_addr,
    output chip_test_pkg::word_t    rd_data
);
    import chip_test_pkg::*;

    // whole pattern image, filled through the load port
    word_t mem [0:(1 << `ADDR_W) - 1];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // registered read, word shows up the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hw/bus_output_stage.sv ====
`timescale 1ns/1ps

module bus_output_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  chip_test_pkg::xfer_state_e  state,
    input  chip_test_pkg::word_t        mem_data,
    output chip_test_pkg::word_t        data_out,
    output logic                        oe_n,
    output logic                        cs_n
);
    import chip_test_pkg::*;

    logic in_rd;    // RD_DATA phase
    logic rd_q;     // phase one cycle late, for the pad turnaround

    assign in_rd = (state == RD_DATA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= in_rd;
        end
    end

    // ==========================================================
    // bus drive
    // ==========================================================
    // word was read a cycle ahead and already sits in the memory
    // output register, so it lines up with the RD_DATA cycle here
    assign data_out = in_rd ? mem_data : '0;
    assign cs_n     = !in_rd;
    assign oe_n     = !(in_rd || rd_q);     // one extra cycle of drive

endmodule

// ==== hw/chip_test_bridge.sv ====
`timescale 1ns/1ps

module chip_test_bridge (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    config_req,
    input  logic                    switch_rdwr,    // 1 read, 0 write
    input  chip_test_pkg::word_t    data_in,
    input  logic                    load_en,
    input  chip_test_pkg::addr_t    load_addr,
    input  chip_test_pkg::word_t    load_data,
    output chip_test_pkg::word_t    data_out,
    output logic                    oe_n,
    output logic                    cs_n,
    output logic                    error,
    output logic                    chip_clk_en,
    output logic                    chip_reset_n
);

    chip_test_pkg::xfer_state_e state;
    chip_test_pkg::xfer_state_e next_state;
    chip_test_pkg::ifcode_e     code;
    logic                       xfer_done;
    chip_test_pkg::addr_t       mem_addr;
    logic                       mem_en;
    chip_test_pkg::word_t       mem_data;

    // ==========================================================
    // chip clock switch and reset
    // ==========================================================
    chip_reset_sequencer u_rst_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .xfer_done    (xfer_done),
        .code         (code),
        .error        (error),
        .chip_clk_en  (chip_clk_en),
        .chip_reset_n (chip_reset_n)
    );

    // ==========================================================
    // transfer path
    // ==========================================================
    transfer_sequencer u_xfer_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .config_req (config_req),
        .data_in    (data_in),
        .state      (state),
        .next_state (next_state),
        .code       (code),
        .xfer_done  (xfer_done),
        .error      (error)
    );

    region_addresser u_addr (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .next_state  (next_state),
        .code        (code),
        .xfer_done   (xfer_done),
        .switch_rdwr (switch_rdwr),
        .mem_addr    (mem_addr),
        .mem_en      (mem_en)
    );

    pattern_memory u_mem (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (mem_en),
        .rd_addr   (mem_addr),
        .rd_data   (mem_data)
    );

    bus_output_stage u_bus (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .mem_data (mem_data),
        .data_out (data_out),
        .oe_n     (oe_n),
        .cs_n     (cs_n)
    );

endmodule

// ==== tb/tb_bridge_model.svh ====
`ifndef TB_BRIDGE_MODEL_SVH
`define TB_BRIDGE_MODEL_SVH

// ============================================================
// reference model, lives inside the testbench module
// ============================================================

// interface codes as the ASIC sends them
localparam logic [3:0] CODE_CFG     = 4'd0;
localparam logic [3:0] CODE_FLGOFM  = 4'd1;
localparam logic [3:0] CODE_OFM     = 4'd2;
localparam logic [3:0] CODE_WEIADDR = 4'd3;
localparam logic [3:0] CODE_WEI     = 4'd4;
localparam logic [3:0] CODE_FLGWEI  = 4'd5;
localparam logic [3:0] CODE_ACT     = 4'd6;
localparam logic [3:0] CODE_FLGACT  = 4'd7;
localparam logic [3:0] CODE_EMPTY   = 4'd15;

// regions sit in memory in this order, back to back
localparam logic [3:0] REGION_ORDER [8] = '{CODE_CFG, CODE_WEIADDR, CODE_FLGWEI, CODE_WEI,
                                            CODE_FLGACT, CODE_ACT, CODE_OFM, CODE_FLGOFM};

logic [`WORD_W-1:0] mem_img [1 << `ADDR_W];     // copy of the loaded image
int                 offset_img [8] = '{default: 0};
logic               seq_active = 1'b0;          // reset sequence waiting in PULLUP_SW
int                 wei_done = 0;
logic               clk_en_exp = 1'b0;

function automatic int xfer_len(input logic [3:0] c);
    case (c)
        CODE_CFG:     return `LEN_CFG;
        CODE_FLGOFM:  return `LEN_FLGOFM;
        CODE_OFM:     return `LEN_OFM;
        CODE_WEIADDR: return `LEN_WEIADDR;
        CODE_WEI:     return `LEN_WEI;
        CODE_FLGWEI:  return `LEN_FLGWEI;
        CODE_ACT:     return `LEN_ACT;
        CODE_FLGACT:  return `LEN_FLGACT;
        default:      return `LEN_DEFAULT;
    endcase
endfunction

function automatic int region_blocks(input logic [3:0] c);
    case (c)
        CODE_WEIADDR, CODE_WEI: return 2;
        CODE_ACT, CODE_FLGACT:  return 4;
        default:                return 1;
    endcase
endfunction

// walk the packing order and sum up the sizes in front of c
function automatic int region_start(input logic [3:0] c);
    int pos;
    pos = 0;
    for (int i = 0; i < 8; i++) begin
        if (REGION_ORDER[i] == c) begin
            return pos;
        end
        pos += xfer_len(REGION_ORDER[i]) * region_blocks(REGION_ORDER[i]);
    end
    return 0;   // unknown code reads from the bottom of memory
endfunction

function automatic logic [`ADDR_W-1:0] start_address(input logic [3:0] c);
    if (c > 4'd7) begin
        return '0;
    end
    return `ADDR_W'(region_start(c) + offset_img[c[2:0]]);
endfunction

// pointer step and release rules, applied once a transfer is over
task automatic finish_transfer(input logic [3:0] c, input logic rdwr, input logic inject);
    if (c <= 4'd7 && rdwr) begin
        offset_img[c[2:0]] += xfer_len(c);
        if (offset_img[c[2:0]] >= xfer_len(c) * region_blocks(c)) begin
            offset_img[c[2:0]] = 0;     // wrap
        end
    end
    if (seq_active && c == CODE_WEIADDR) begin
        wei_done++;
    end
    if (seq_active && (wei_done >= `RELEASE_COUNT || inject)) begin
        seq_active = 1'b0;
    end
endtask

`endif

// ==== tb/tb_chip_test_bridge.sv ====
`timescale 1ns/1ps
`include "chip_test_defines.svh"

module tb_chip_test_bridge;

    localparam int N_REQ      = 40;
    localparam int MAX_CYCLES = (1 << `ADDR_W) + (N_REQ + 16) * (`LEN_ACT + 10) + 200;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               start;
    logic               config_req;
    logic               switch_rdwr;
    logic [`WORD_W-1:0] data_in;
    logic               load_en;
    logic [`ADDR_W-1:0] load_addr;
    logic [`WORD_W-1:0] load_data;
    logic [`WORD_W-1:0] data_out;
    logic               oe_n;
    logic               cs_n;
    logic               error;
    logic               chip_clk_en;
    logic               chip_reset_n;

    logic [31:0]        lfsr = 32'ha9d4_4683;
    int                 err_count = 0;
    int                 check_count = 0;
    int                 cycle_count = 0;

    `include "tb_bridge_model.svh"

    chip_test_bridge uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .config_req   (config_req),
        .switch_rdwr  (switch_rdwr),
        .data_in      (data_in),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .data_out     (data_out),
        .oe_n         (oe_n),
        .cs_n         (cs_n),
        .error        (error),
        .chip_clk_en  (chip_clk_en),
        .chip_reset_n (chip_reset_n)
    );

    always #4 clk = ~clk;

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit handed out
    function automatic logic [`WORD_W-1:0] rand_bits(input int n);
        logic [`WORD_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[`WORD_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input logic [`WORD_W-1:0] exp,
                            input logic [`WORD_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic load_memory();
        for (int a = 0; a < (1 << `ADDR_W); a++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = `ADDR_W'(a);
            load_data = rand_bits(`WORD_W);
            mem_img[a] = load_data;
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // start is ignored unless the sequence is back in idle
    task automatic pulse_start();
        logic active;
        active = seq_active;
        @(negedge clk);
        start = 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            start = 1'b0;
            check_eq("chip_clk_en", active ? 1 : (i == 3), chip_clk_en);
            check_eq("chip_reset_n", active ? 1 : (i != 1), chip_reset_n);
        end
        if (!active) begin
            seq_active = 1'b1;
            wei_done   = 0;
            clk_en_exp = 1'b1;
        end
    endtask

    // ==========================================================
    // one request checked cycle by cycle on the bus
    // ==========================================================
    task automatic run_transfer(input logic [3:0] c, input logic rdwr, input logic inject);
        int                 waited;
        int                 k;
        int                 pulses;
        int                 len;
        logic [`ADDR_W-1:0] first;
        logic [`ADDR_W-1:0] a;
        len    = xfer_len(c);
        first  = start_address(c);
        waited = 0;
        k      = 0;
        pulses = 0;
        @(negedge clk);
        config_req  = 1'b1;
        switch_rdwr = rdwr;
        data_in     = rand_bits(`WORD_W);
        data_in[`CODE_LSB +: 4] = c;
        @(negedge clk);
        config_req = 1'b0;
        while (cs_n && waited < 8) begin
            if (error) begin
                pulses++;
            end
            @(negedge clk);
            waited++;
        end
        if (cs_n) begin
            $display("chip select never went low after the request for code %0d", c);
            err_count++;
            return;
        end
        while (!cs_n && k <= len) begin
            a = first + `ADDR_W'(k);
            check_eq("data_out", mem_img[a], data_out);
            check_eq("oe_n", 0, oe_n);
            if (error) begin
                pulses++;
            end
            config_req = inject && (k == 0);    // request while busy
            k++;
            @(negedge clk);
        end
        config_req = 1'b0;
        check_eq("cs_n low cycles", len, k);
        check_eq("oe_n", 0, oe_n);              // turnaround cycle
        check_eq("data_out", 0, data_out);
        if (error) begin
            pulses++;
        end
        @(negedge clk);
        check_eq("oe_n", 1, oe_n);
        if (error) begin
            pulses++;
        end
        check_eq("error pulses", inject, pulses);
        check_eq("chip_clk_en", clk_en_exp, chip_clk_en);
        check_eq("chip_reset_n", 1, chip_reset_n);
        finish_transfer(c, rdwr, inject);
    endtask

    // ==========================================================
    // main sequence
    // ==========================================================
    initial begin
        logic [`WORD_W-1:0] r;
        logic [3:0]         c;
        logic               rdwr;
        logic               inject;
        rst_n       = 1'b0;
        start       = 1'b0;
        config_req  = 1'b0;
        switch_rdwr = 1'b0;
        data_in     = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_eq("cs_n", 1, cs_n);
        check_eq("oe_n", 1, oe_n);
        check_eq("data_out", 0, data_out);
        check_eq("error", 0, error);
        check_eq("chip_clk_en", 0, chip_clk_en);
        check_eq("chip_reset_n", 1, chip_reset_n);

        load_memory();

        // release after the third weight-address transfer and start ignored before that
        pulse_start();
        run_transfer(CODE_WEIADDR, 1'b1, 1'b0);
        run_transfer(CODE_WEIADDR, 1'b0, 1'b0);
        pulse_start();
        run_transfer(CODE_WEIADDR, 1'b1, 1'b0);
        pulse_start();
        run_transfer(CODE_CFG, 1'b1, 1'b1);     // error releases too
        pulse_start();

        for (int n = 0; n < N_REQ; n++) begin
            r = rand_bits(3);
            c = r[3:0];
            r = rand_bits(2);
            if (r[1:0] == 2'b11) begin
                c = CODE_EMPTY;
            end
            r = rand_bits(1);
            rdwr = r[0];
            r = rand_bits(3);
            inject = (r[2:0] == 3'd0);
            r = rand_bits(4);
            if (r[3:0] == 4'd0) begin
                pulse_start();
            end
            run_transfer(c, rdwr, inject);
        end

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        $display("checks: %0d, errors: %0d", check_count, err_count + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== chip_test_bridge.f ====
+incdir+hw
+incdir+tb
hw/chip_test_pkg.sv
hw/chip_reset_sequencer.sv
hw/transfer_sequencer.sv
hw/region_addresser.sv
hw/pattern_memory.sv
hw/bus_output_stage.sv
hw/chip_test_bridge.sv
tb/tb_chip_test_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f chip_test_bridge.f \
    --top-module tb_chip_test_bridge \
    -o sim_tb

output=$(./obj_dir/sim_tb 2>&1)
echo "$output"
grep -q "Simulation finished: PASS" <<< "$output"
